// ==== Bender.yml ====
package:
  name: ne_corner_router

sources:
  - design/noc_pkg.sv
  - design/xbar_ctrl_if.sv
  - design/input_buffer.sv
  - design/credit_counter.sv
  - design/yx_arbiter.sv
  - design/crossbar_switch.sv
  - design/ne_corner_router.sv
  - target: simulation
    files:
      - bench/ne_corner_router_tb.sv

// ==== bench/ne_corner_router_tb.sv ====
// NE corner router testbench
// Table-driven traffic, credit model and scoreboard

`timescale 1ns/1ps

module ne_corner_router_tb;

  localparam int BUF_DEPTH   = 4;
  localparam int CREDIT_INIT = 4;
  localparam int NP          = noc_pkg::NUM_PORTS;
  localparam int NCASE       = 9;
  localparam int REPEAT      = 3;
  localparam int DRAIN_LIMIT = 2000;

  localparam noc_pkg::coord_t ROUTER_X = 4'd3;
  localparam noc_pkg::coord_t ROUTER_Y = 4'd3;
  localparam string PNAME [NP] = '{"s", "w", "l"};

  // Input port, destination x and y, output given by YX at (3,3)
  typedef struct packed {
    noc_pkg::port_sel_t src;
    noc_pkg::coord_t    dx;
    noc_pkg::coord_t    dy;
    noc_pkg::port_sel_t dst;
  } route_case_t;

  localparam route_case_t CASES [NCASE] = '{
    '{2'd0, 4'd3, 4'd3, 2'd2},
    '{2'd0, 4'd1, 4'd3, 2'd1},
    '{2'd0, 4'd3, 4'd0, 2'd0},
    '{2'd1, 4'd3, 4'd1, 2'd0},
    '{2'd1, 4'd3, 4'd3, 2'd2},
    '{2'd1, 4'd0, 4'd3, 2'd1},
    '{2'd2, 4'd0, 4'd2, 2'd0},
    '{2'd2, 4'd2, 4'd3, 2'd1},
    '{2'd2, 4'd3, 4'd3, 2'd2}
  };

  logic           clk;
  logic           rst_i;
  noc_pkg::flit_t data_in  [NP];
  logic [NP-1:0]  valid_in;
  logic [NP-1:0]  credit_in;
  noc_pkg::flit_t data_out [NP];
  logic [NP-1:0]  valid_out;
  logic [NP-1:0]  credit_out;

  // Traffic still to send, with its expected output
  noc_pkg::flit_t send_q  [NP][$];
  int             route_q [NP][$];
  // Scoreboard, one queue per output and input pair
  noc_pkg::flit_t exp_q   [NP*NP][$];
  // Cycle at which each downstream slot frees
  int             ret_q   [NP][$];
  int             up_cred [NP];
  int             wr_cnt  [NP];
  int             cr_cnt  [NP];
  int             arr_cnt [NP];
  int             last_src [NP];
  logic [NP-1:0]  hold;
  logic [NP-1:0]  alt_chk;
  int             cyc;

  ne_corner_router #(
    .BUF_DEPTH(BUF_DEPTH),
    .CREDIT_INIT(CREDIT_INIT)
  ) uut (
    .clk(clk), .rst_i(rst_i), .router_x_i(ROUTER_X), .router_y_i(ROUTER_Y),
    .s_data_i(data_in[0]), .s_valid_i(valid_in[0]), .s_credit_i(credit_in[0]),
    .s_data_o(data_out[0]), .s_valid_o(valid_out[0]), .s_credit_o(credit_out[0]),
    .w_data_i(data_in[1]), .w_valid_i(valid_in[1]), .w_credit_i(credit_in[1]),
    .w_data_o(data_out[1]), .w_valid_o(valid_out[1]), .w_credit_o(credit_out[1]),
    .l_data_i(data_in[2]), .l_valid_i(valid_in[2]), .l_credit_i(credit_in[2]),
    .l_data_o(data_out[2]), .l_valid_o(valid_out[2]), .l_credit_o(credit_out[2])
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Payload top bits carry the source input
  task automatic queue_flit(input int src, input noc_pkg::coord_t dx,
                            input noc_pkg::coord_t dy, input int dst);
    logic [5:0] tag;
    tag = 6'($urandom);
    send_q[src].push_back({dx, dy, 2'(src), tag});
    route_q[src].push_back(dst);
  endtask

  task automatic score_arrival(input int o, input noc_pkg::flit_t d);
    int src;
    src = int'(d[7:6]);
    if (src >= NP || exp_q[o*NP + src].size() == 0) begin
      $display("Unexpected flit %h on output %s at %0t", d, PNAME[o], $time);
      stop_run();
    end else if (alt_chk[o] && last_src[o] == src) begin
      $display("Input %0d won output %s twice in a row at %0t", src, PNAME[o], $time);
      stop_run();
    end else begin
      check_value({PNAME[o], "_data_o"}, d, exp_q[o*NP + src].pop_front());
      last_src[o] = src;
      arr_cnt[o]++;
    end
  endtask

  function automatic bit traffic_done();
    traffic_done = 1'b1;
    for (int p = 0; p < NP; p++) begin
      if (send_q[p].size() != 0 || ret_q[p].size() != 0) begin
        traffic_done = 1'b0;
      end
    end
    for (int q = 0; q < NP*NP; q++) begin
      if (exp_q[q].size() != 0) begin
        traffic_done = 1'b0;
      end
    end
  endfunction

  task automatic wait_idle(input int limit);
    int n;
    n = 0;
    while (!traffic_done()) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        $display("Timeout: traffic did not drain within %0d cycles", limit);
        stop_run();
      end
    end
    // Let the last credit pulses land
    repeat (4) @(negedge clk);
  endtask

  task automatic wait_arrivals(input int o, input int target, input int limit);
    int n;
    n = 0;
    while (arr_cnt[o] < target) begin
      @(negedge clk);
      n++;
      if (n > limit) begin
        $display("Timeout: output %s delivered too few flits", PNAME[o]);
        stop_run();
      end
    end
  endtask

  // Two inputs stream into one output at the same time
  task automatic contend(input int a, input int b, input noc_pkg::coord_t dx,
                         input noc_pkg::coord_t dy, input int dst);
    alt_chk[dst]  = 1'b1;
    last_src[dst] = NP;
    repeat (BUF_DEPTH) begin
      queue_flit(a, dx, dy, dst);
      queue_flit(b, dx, dy, dst);
    end
    wait_idle(DRAIN_LIMIT);
    alt_chk[dst] = 1'b0;
  endtask

  // Upstream driver, output monitor and downstream credit model
  always @(posedge clk) begin
    int o;
    cyc++;
    if (rst_i) begin
      for (int p = 0; p < NP; p++) begin
        up_cred[p]  = BUF_DEPTH;
        wr_cnt[p]   = 0;
        cr_cnt[p]   = 0;
        arr_cnt[p]  = 0;
        last_src[p] = NP;
      end
      valid_in  <= '0;
      credit_in <= '0;
    end else begin
      for (int p = 0; p < NP; p++) begin
        if (credit_out[p]) begin
          up_cred[p]++;
          cr_cnt[p]++;
        end
        // Slot returned after a random delay unless withheld
        if (!hold[p] && ret_q[p].size() > 0 && ret_q[p][0] <= cyc) begin
          void'(ret_q[p].pop_front());
          credit_in[p] <= 1'b1;
        end else begin
          credit_in[p] <= 1'b0;
        end
        if (valid_out[p]) begin
          score_arrival(p, data_out[p]);
          ret_q[p].push_back(cyc + 1 + int'($urandom % 4));
        end
        // Never write without an upstream credit
        if (send_q[p].size() > 0 && up_cred[p] > 0) begin
          o = route_q[p].pop_front();
          exp_q[o*NP + p].push_back(send_q[p][0]);
          data_in[p]  <= send_q[p].pop_front();
          valid_in[p] <= 1'b1;
          up_cred[p]--;
          wr_cnt[p]++;
        end else begin
          valid_in[p] <= 1'b0;
        end
      end
    end
  end

  initial begin
    int base;
    void'($urandom(32'hfa84_5580));
    rst_i     = 1'b1;
    valid_in  = '0;
    credit_in = '0;
    hold      = '0;
    alt_chk   = '0;
    cyc       = 0;
    for (int p = 0; p < NP; p++) begin
      data_in[p] = '0;
    end
    repeat (16) @(posedge clk);
    rst_i <= 1'b0;

    // Quiet links before the first write
    repeat (6) begin
      @(negedge clk);
      check_value("valid_o", valid_out, '0);
      check_value("credit_o", credit_out, '0);
    end

    // Routing table
    for (int c = 0; c < NCASE; c++) begin
      for (int r = 0; r < REPEAT; r++) begin
        queue_flit(CASES[c].src, CASES[c].dx, CASES[c].dy, CASES[c].dst);
      end
    end
    wait_idle(DRAIN_LIMIT);

    // Round-robin fairness under contention
    contend(0, 1, 4'd3, 4'd3, 2);
    contend(1, 2, 4'd3, 4'd0, 0);
    contend(0, 2, 4'd1, 4'd3, 1);

    // Back-pressure on west output
    hold[1] = 1'b1;
    base    = arr_cnt[1];
    repeat (CREDIT_INIT + 3) begin
      queue_flit(2, 4'd1, 4'd3, 1);
    end
    wait_arrivals(1, base + CREDIT_INIT, 500);
    repeat (20) @(negedge clk);
    check_value("w_valid_o flits without credit", arr_cnt[1] - base, CREDIT_INIT);
    hold[1] = 1'b0;
    wait_idle(DRAIN_LIMIT);

    // One credit_o pulse per written flit
    for (int p = 0; p < NP; p++) begin
      check_value({PNAME[p], "_credit_o pulses"}, cr_cnt[p], wr_cnt[p]);
    end

    $display("Verification passed");
    $finish;
  end

endmodule

// ==== design/credit_counter.sv ====
// Downstream credit counter

`timescale 1ns/1ps

module credit_counter #(
  parameter int CREDIT_INIT = 4
) (
  input  logic clk,
  input  logic rst_i,
  input  logic dec_i,
  input  logic inc_i,
  output logic has_credit_o
);

  localparam int CNT_W = $clog2(CREDIT_INIT + 1);

  // Free slots downstream
  logic [CNT_W-1:0] count;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      count <= CNT_W'(CREDIT_INIT);
    end else if (dec_i && !inc_i && count != '0) begin
      // Flit sent
      count <= count - 1'b1;
    end else if (inc_i && !dec_i && count != CNT_W'(CREDIT_INIT)) begin
      // Slot freed downstream
      count <= count + 1'b1;
    end
  end

  assign has_credit_o = (count != '0);

endmodule

// ==== design/crossbar_switch.sv ====
// Registered 3x3 flit switch

`timescale 1ns/1ps

module crossbar_switch (
  input  logic           clk,
  input  logic           rst_i,
  input  noc_pkg::flit_t head_s_i,
  input  noc_pkg::flit_t head_w_i,
  input  noc_pkg::flit_t head_l_i,
  xbar_ctrl_if.xbar      ctrl,
  output noc_pkg::flit_t data_s_o,
  output noc_pkg::flit_t data_w_o,
  output noc_pkg::flit_t data_l_o,
  output logic           valid_s_o,
  output logic           valid_w_o,
  output logic           valid_l_o
);

  localparam int NP = noc_pkg::NUM_PORTS;

  noc_pkg::flit_t     head   [NP];
  noc_pkg::flit_t     data_q [NP];
  noc_pkg::port_sel_t sel    [NP];
  logic [NP-1:0]      fire;
  logic [NP-1:0]      valid_q;

  assign head = '{head_s_i, head_w_i, head_l_i};
  assign sel  = '{ctrl.sel_s, ctrl.sel_w, ctrl.sel_l};
  assign fire = {ctrl.fire_l, ctrl.fire_w, ctrl.fire_s};

  // Mux and load data on fire, payload not reset
  always_ff @(posedge clk) begin
    for (int o = 0; o < NP; o++) begin
      if (fire[o]) begin
        data_q[o] <= head[sel[o]];
      end
    end
  end

  // Valid for one cycle per fire
  always_ff @(posedge clk) begin
    if (rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q <= fire;
    end
  end

  assign data_s_o  = data_q[noc_pkg::PORT_S];
  assign data_w_o  = data_q[noc_pkg::PORT_W];
  assign data_l_o  = data_q[noc_pkg::PORT_L];
  assign valid_s_o = valid_q[noc_pkg::PORT_S];
  assign valid_w_o = valid_q[noc_pkg::PORT_W];
  assign valid_l_o = valid_q[noc_pkg::PORT_L];

endmodule

// ==== design/input_buffer.sv ====
// Input flit FIFO

`timescale 1ns/1ps

module input_buffer #(
  parameter int BUF_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_i,
  input  noc_pkg::flit_t data_i,
  input  logic           write_i,
  input  logic           pop_i,
  output noc_pkg::flit_t head_o,
  output logic           empty_o
);

  localparam int PTR_W = $clog2(BUF_DEPTH);
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Flit storage
  noc_pkg::flit_t ram [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  logic full;
  logic do_write;
  logic do_pop;

  assign full    = (count == CNT_W'(BUF_DEPTH));
  assign empty_o = (count == '0);

  // Upstream credits keep writes off a full buffer
  assign do_write = write_i && !full;
  assign do_pop   = pop_i && !empty_o;

  // Storage write, no reset
  always_ff @(posedge clk) begin
    if (do_write) begin
      ram[wr_ptr] <= data_i;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // Simultaneous write and pop leave occupancy as is
      if (do_write && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_write) begin
        count <= count - 1'b1;
      end
    end
  end

  // Head of queue
  assign head_o = ram[rd_ptr];

endmodule

// ==== design/ne_corner_router.sv ====
// North-east corner router

`timescale 1ns/1ps

module ne_corner_router #(
  parameter int BUF_DEPTH   = 4,
  parameter int CREDIT_INIT = 4
) (
  input  logic            clk,
  input  logic            rst_i,
  input  noc_pkg::coord_t router_x_i,
  input  noc_pkg::coord_t router_y_i,
  // South link
  input  noc_pkg::flit_t  s_data_i,
  input  logic            s_valid_i,
  input  logic            s_credit_i,
  output noc_pkg::flit_t  s_data_o,
  output logic            s_valid_o,
  output logic            s_credit_o,
  // West link
  input  noc_pkg::flit_t  w_data_i,
  input  logic            w_valid_i,
  input  logic            w_credit_i,
  output noc_pkg::flit_t  w_data_o,
  output logic            w_valid_o,
  output logic            w_credit_o,
  // Local link
  input  noc_pkg::flit_t  l_data_i,
  input  logic            l_valid_i,
  input  logic            l_credit_i,
  output noc_pkg::flit_t  l_data_o,
  output logic            l_valid_o,
  output logic            l_credit_o
);

  noc_pkg::flit_t head_s, head_w, head_l;
  logic empty_s, empty_w, empty_l;
  logic pop_s, pop_w, pop_l;
  logic has_credit_s, has_credit_w, has_credit_l;

  xbar_ctrl_if xbar_ctrl ();

  // Input buffers
  input_buffer #(.BUF_DEPTH(BUF_DEPTH)) ib_s (
    .clk(clk), .rst_i(rst_i), .data_i(s_data_i), .write_i(s_valid_i),
    .pop_i(pop_s), .head_o(head_s), .empty_o(empty_s)
  );
  input_buffer #(.BUF_DEPTH(BUF_DEPTH)) ib_w (
    .clk(clk), .rst_i(rst_i), .data_i(w_data_i), .write_i(w_valid_i),
    .pop_i(pop_w), .head_o(head_w), .empty_o(empty_w)
  );
  input_buffer #(.BUF_DEPTH(BUF_DEPTH)) ib_l (
    .clk(clk), .rst_i(rst_i), .data_i(l_data_i), .write_i(l_valid_i),
    .pop_i(pop_l), .head_o(head_l), .empty_o(empty_l)
  );

  // Credit counters, fire is the decrement
  credit_counter #(.CREDIT_INIT(CREDIT_INIT)) cc_s (
    .clk(clk), .rst_i(rst_i), .dec_i(xbar_ctrl.fire_s), .inc_i(s_credit_i),
    .has_credit_o(has_credit_s)
  );
  credit_counter #(.CREDIT_INIT(CREDIT_INIT)) cc_w (
    .clk(clk), .rst_i(rst_i), .dec_i(xbar_ctrl.fire_w), .inc_i(w_credit_i),
    .has_credit_o(has_credit_w)
  );
  credit_counter #(.CREDIT_INIT(CREDIT_INIT)) cc_l (
    .clk(clk), .rst_i(rst_i), .dec_i(xbar_ctrl.fire_l), .inc_i(l_credit_i),
    .has_credit_o(has_credit_l)
  );

  // Route and allocate
  yx_arbiter arb (
    .clk(clk), .rst_i(rst_i),
    .router_x_i(router_x_i), .router_y_i(router_y_i),
    .head_s_i(head_s), .head_w_i(head_w), .head_l_i(head_l),
    .empty_s_i(empty_s), .empty_w_i(empty_w), .empty_l_i(empty_l),
    .has_credit_s_i(has_credit_s), .has_credit_w_i(has_credit_w),
    .has_credit_l_i(has_credit_l),
    .pop_s_o(pop_s), .pop_w_o(pop_w), .pop_l_o(pop_l),
    .ctrl(xbar_ctrl.arb)
  );

  // Output registers
  crossbar_switch xbar (
    .clk(clk), .rst_i(rst_i),
    .head_s_i(head_s), .head_w_i(head_w), .head_l_i(head_l),
    .ctrl(xbar_ctrl.xbar),
    .data_s_o(s_data_o), .data_w_o(w_data_o), .data_l_o(l_data_o),
    .valid_s_o(s_valid_o), .valid_w_o(w_valid_o), .valid_l_o(l_valid_o)
  );

  // Freed slot goes back upstream with the pop
  assign s_credit_o = pop_s;
  assign w_credit_o = pop_w;
  assign l_credit_o = pop_l;

endmodule

// ==== design/noc_pkg.sv ====
// Mesh NoC shared types
// Flit layout and port indices

package noc_pkg;

  // One flit, one packet
  typedef logic [15:0] flit_t;

  // Mesh coordinate
  typedef logic [3:0] coord_t;

  // Input/output port index
  typedef logic [1:0] port_sel_t;

  // Port indices at the north-east corner
  localparam port_sel_t PORT_S = 2'd0;
  localparam port_sel_t PORT_W = 2'd1;
  localparam port_sel_t PORT_L = 2'd2;

  // Ports present at this corner
  localparam int NUM_PORTS = 3;

  // Destination x from header, bits 15..12
  function automatic coord_t flit_dest_x(input flit_t flit);
    flit_dest_x = flit[15:12];
  endfunction

  // Destination y, bits 11..8
  function automatic coord_t flit_dest_y(input flit_t flit);
    flit_dest_y = flit[11:8];
  endfunction

endpackage

// ==== design/xbar_ctrl_if.sv ====
// Crossbar control bundle

`timescale 1ns/1ps

interface xbar_ctrl_if;

  // Selected input per output
  noc_pkg::port_sel_t sel_s;
  noc_pkg::port_sel_t sel_w;
  noc_pkg::port_sel_t sel_l;

  // Output takes a flit this cycle
  logic fire_s;
  logic fire_w;
  logic fire_l;

  // Arbiter side
  modport arb (output sel_s, sel_w, sel_l, fire_s, fire_w, fire_l);

  // Crossbar side
  modport xbar (input sel_s, sel_w, sel_l, fire_s, fire_w, fire_l);

endinterface

// ==== design/yx_arbiter.sv ====
// YX routing and round-robin allocation

`timescale 1ns/1ps

module yx_arbiter (
  input  logic             clk,
  input  logic             rst_i,
  input  noc_pkg::coord_t  router_x_i,
  input  noc_pkg::coord_t  router_y_i,
  input  noc_pkg::flit_t   head_s_i,
  input  noc_pkg::flit_t   head_w_i,
  input  noc_pkg::flit_t   head_l_i,
  input  logic             empty_s_i,
  input  logic             empty_w_i,
  input  logic             empty_l_i,
  input  logic             has_credit_s_i,
  input  logic             has_credit_w_i,
  input  logic             has_credit_l_i,
  output logic             pop_s_o,
  output logic             pop_w_o,
  output logic             pop_l_o,
  xbar_ctrl_if.arb         ctrl
);

  localparam int NP = noc_pkg::NUM_PORTS;

  noc_pkg::flit_t     head  [NP];
  noc_pkg::port_sel_t route [NP];
  noc_pkg::port_sel_t ptr   [NP];
  noc_pkg::port_sel_t win   [NP];
  logic [NP-1:0]      req   [NP];
  logic [NP-1:0]      empty;
  logic [NP-1:0]      credit;
  logic [NP-1:0]      fire;
  logic [NP-1:0]      pop;

  // First requester at or after the pointer
  function automatic noc_pkg::port_sel_t rr_pick(input logic [NP-1:0] r,
                                                 input noc_pkg::port_sel_t p);
    int idx;
    rr_pick = p;
    // Farthest first, nearest overwrites
    for (int k = NP - 1; k >= 0; k--) begin
      idx = (int'(p) + k) % NP;
      if (r[idx]) begin
        rr_pick = noc_pkg::port_sel_t'(idx);
      end
    end
  endfunction

  // Port after the winner, wrapping
  function automatic noc_pkg::port_sel_t next_port(input noc_pkg::port_sel_t p);
    next_port = (int'(p) == NP - 1) ? noc_pkg::PORT_S : p + 1'b1;
  endfunction

  // Inputs as arrays indexed by port
  assign head   = '{head_s_i, head_w_i, head_l_i};
  assign empty  = {empty_l_i, empty_w_i, empty_s_i};
  assign credit = {has_credit_l_i, has_credit_w_i, has_credit_s_i};

  always_comb begin
    // YX route of each head flit
    for (int i = 0; i < NP; i++) begin
      if (noc_pkg::flit_dest_y(head[i]) != router_y_i) begin
        route[i] = noc_pkg::PORT_S;
      end else if (noc_pkg::flit_dest_x(head[i]) != router_x_i) begin
        route[i] = noc_pkg::PORT_W;
      end else begin
        route[i] = noc_pkg::PORT_L;
      end
    end
    // Request matrix, req[output][input]
    for (int o = 0; o < NP; o++) begin
      for (int i = 0; i < NP; i++) begin
        req[o][i] = !empty[i] && (int'(route[i]) == o);
      end
    end
    // One pick per output, gated by credit
    for (int o = 0; o < NP; o++) begin
      win[o]  = rr_pick(req[o], ptr[o]);
      fire[o] = (|req[o]) && credit[o];
    end
    // Pop every granted input
    pop = '0;
    for (int o = 0; o < NP; o++) begin
      if (fire[o]) begin
        pop[win[o]] = 1'b1;
      end
    end
  end

  // Pointer moves past the winner on grant
  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int o = 0; o < NP; o++) begin
        ptr[o] <= noc_pkg::PORT_S;
      end
    end else begin
      for (int o = 0; o < NP; o++) begin
        if (fire[o]) begin
          ptr[o] <= next_port(win[o]);
        end
      end
    end
  end

  assign pop_s_o = pop[noc_pkg::PORT_S];
  assign pop_w_o = pop[noc_pkg::PORT_W];
  assign pop_l_o = pop[noc_pkg::PORT_L];

  // Crossbar control
  assign ctrl.sel_s  = win[noc_pkg::PORT_S];
  assign ctrl.sel_w  = win[noc_pkg::PORT_W];
  assign ctrl.sel_l  = win[noc_pkg::PORT_L];
  assign ctrl.fire_s = fire[noc_pkg::PORT_S];
  assign ctrl.fire_w = fire[noc_pkg::PORT_W];
  assign ctrl.fire_l = fire[noc_pkg::PORT_L];

endmodule

// ==== files.f ====
design/noc_pkg.sv
design/xbar_ctrl_if.sv
design/input_buffer.sv
design/credit_counter.sv
design/yx_arbiter.sv
design/crossbar_switch.sv
design/ne_corner_router.sv
bench/ne_corner_router_tb.sv
